//--- include/mm_ram_config.svh
// Memory map and sizing for the harness memory.
// RAM occupies byte addresses 0 .. 2**MM_RAM_ADDR_WIDTH-1.
// Peripheral addresses are matched exactly, so sub-word offsets are unmapped.

`ifndef MM_RAM_CONFIG_SVH
`define MM_RAM_CONFIG_SVH

// byte address width of the RAM region, 12 gives 4 KiB
`define MM_RAM_ADDR_WIDTH 12

// test status register, a write of the pass or fail code pulses a strobe
`define MM_STATUS_ADDR 32'h2000_0000

// exit register, a write pulses exit valid with the written value
`define MM_EXIT_ADDR 32'h2000_0004

// timer interrupt mask and countdown value
`define MM_TIMER_MASK_ADDR 32'h1500_0000
`define MM_TIMER_CNT_ADDR 32'h1500_0004

// status codes written by the test program
`define MM_PASS_VALUE 32'd123456789
`define MM_FAIL_VALUE 32'd1

// interrupt id of the timer, also the enable bit in the mask register
`define MM_TIMER_IRQ_ID 7

`endif

//--- src/mm_ram_pkg.sv
// Shared types for the harness memory.
// RAM word index width follows MM_RAM_ADDR_WIDTH from the config header.

`include "mm_ram_config.svh"

package mm_ram_pkg;

    // data and address words on the core ports
    typedef logic [31:0] word_t;

    // one enable bit per byte lane
    typedef logic [3:0] be_t;

    // word index into the RAM, byte offset dropped
    typedef logic [`MM_RAM_ADDR_WIDTH-3:0] ram_addr_t;

    // one requester's access toward the RAM
    typedef struct packed {
        logic      req;
        logic      we;
        be_t       be;
        ram_addr_t addr;
        word_t     wdata;
    } ram_req_t;

    // decoded write to one of the timer registers
    typedef struct packed {
        logic  mask_we;
        logic  cnt_we;
        word_t wdata;
    } timer_wr_t;

    // data port response state, tracks what was granted in the last cycle
    typedef enum logic [1:0] {
        RSP_IDLE,
        RSP_PERIPH_VALID,
        RSP_WAIT_RAM
    } rsp_state_e;

endpackage

//--- src/data_decoder.sv
// Data port decoder, RAM region goes to the arbiter, the rest is local.
// Peripheral and unmapped accesses are granted at once and answer next cycle.
// Unmapped reads return zero, unmapped writes are dropped.

`timescale 1ns/1ps

`include "mm_ram_config.svh"

module data_decoder import mm_ram_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,

    input  logic      data_req_i,
    input  word_t     data_addr_i,
    input  logic      data_we_i,
    input  be_t       data_be_i,
    input  word_t     data_wdata_i,
    output logic      data_gnt_o,
    output logic      data_rvalid_o,
    output word_t     data_rdata_o,

    output ram_req_t  data_ram_req_o,
    input  logic      data_gnt_i,
    input  logic      data_rvalid_i,
    input  word_t     ram_rdata_i,

    output timer_wr_t timer_wr_o,
    output logic      tests_passed_o,
    output logic      tests_failed_o,
    output logic      exit_valid_o,
    output word_t     exit_value_o
);

    logic       is_ram;
    logic       status_wr;
    logic       exit_wr;
    rsp_state_e state_d;
    rsp_state_e state_q;

    // anything below 2**MM_RAM_ADDR_WIDTH is RAM
    assign is_ram = (data_addr_i[31:`MM_RAM_ADDR_WIDTH] == '0);

    assign status_wr = data_req_i && data_we_i && (data_addr_i == `MM_STATUS_ADDR);
    assign exit_wr   = data_req_i && data_we_i && (data_addr_i == `MM_EXIT_ADDR);

    assign data_ram_req_o = '{
        req:   data_req_i && is_ram,
        we:    data_we_i,
        be:    data_be_i,
        addr:  data_addr_i[`MM_RAM_ADDR_WIDTH-1:2],
        wdata: data_wdata_i
    };

    // local targets never stall, so their strobes coincide with the grant
    assign tests_passed_o = status_wr && (data_wdata_i == `MM_PASS_VALUE);
    assign tests_failed_o = status_wr && (data_wdata_i == `MM_FAIL_VALUE);
    assign exit_valid_o   = exit_wr;
    assign exit_value_o   = exit_wr ? data_wdata_i : '0;

    assign timer_wr_o = '{
        mask_we: data_req_i && data_we_i && (data_addr_i == `MM_TIMER_MASK_ADDR),
        cnt_we:  data_req_i && data_we_i && (data_addr_i == `MM_TIMER_CNT_ADDR),
        wdata:   data_wdata_i
    };

    // RAM requests wait for the arbiter, everything else is taken at once
    assign data_gnt_o = data_req_i && (is_ram ? data_gnt_i : 1'b1);

    // remember what kind of access was accepted this cycle
    always_comb begin
        state_d = RSP_IDLE;
        if (data_gnt_o) begin
            state_d = is_ram ? RSP_WAIT_RAM : RSP_PERIPH_VALID;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= RSP_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // the state doubles as the read select for the response cycle
    always_comb begin
        data_rvalid_o = 1'b0;
        data_rdata_o  = '0;
        unique case (state_q)
            RSP_PERIPH_VALID: begin
                data_rvalid_o = 1'b1;
            end
            RSP_WAIT_RAM: begin
                data_rvalid_o = data_rvalid_i;
                data_rdata_o  = ram_rdata_i;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- src/mem_arbiter.sv
// Fixed-priority arbiter in front of the single-port RAM.
// Data wins every conflict, a losing fetch just holds its request.
// Read valid follows each grant by exactly one cycle.

`timescale 1ns/1ps

module mem_arbiter import mm_ram_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_ni,

    input  ram_req_t instr_req_i,
    input  ram_req_t data_req_i,
    output logic     instr_gnt_o,
    output logic     data_gnt_o,
    output logic     instr_rvalid_o,
    output logic     data_rvalid_o,

    output ram_req_t ram_req_o,
    input  word_t    ram_rdata_i,
    output word_t    ram_rdata_o
);

    logic instr_rvalid_q;
    logic data_rvalid_q;

    // data port has priority
    assign data_gnt_o  = data_req_i.req;
    assign instr_gnt_o = instr_req_i.req && !data_req_i.req;

    // route the winner to the RAM, an idle instr request carries req low
    always_comb begin
        if (data_req_i.req) begin
            ram_req_o = data_req_i;
        end else begin
            ram_req_o = instr_req_i;
        end
    end

    // note which port owns next cycle's read data
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_q <= 1'b0;
            data_rvalid_q  <= 1'b0;
        end else begin
            instr_rvalid_q <= instr_gnt_o;
            data_rvalid_q  <= data_gnt_o;
        end
    end

    assign instr_rvalid_o = instr_rvalid_q;
    assign data_rvalid_o  = data_rvalid_q;

    // one read bus for both ports, the rvalids tell them apart
    assign ram_rdata_o = ram_rdata_i;

endmodule

//--- src/sram_model.sv
// Single-port word RAM with byte enables and a registered read port.
// Contents are undefined until written, there is no reset or preload.
// A write leaves the read register unchanged.

`timescale 1ns/1ps

`include "mm_ram_config.svh"

module sram_model import mm_ram_pkg::*; (
    input  logic     clk_i,
    input  ram_req_t req_i,
    output word_t    rdata_o
);

    localparam int unsigned depth = 2 ** (`MM_RAM_ADDR_WIDTH - 2);

    word_t mem [depth];

    // byte-lane write
    always_ff @(posedge clk_i) begin
        if (req_i.req && req_i.we) begin
            for (int i = 0; i < 4; i++) begin
                if (req_i.be[i]) begin
                    mem[req_i.addr][8*i +: 8] <= req_i.wdata[8*i +: 8];
                end
            end
        end
    end

    // read data shows up the cycle after the request
    always_ff @(posedge clk_i) begin
        if (req_i.req && !req_i.we) begin
            rdata_o <= mem[req_i.addr];
        end
    end

endmodule

//--- src/periph_timer.sv
// Down-counting timer with a 32-bit interrupt mask.
// The irq rises when the count steps from 1 to 0 and the timer mask bit is set.
// It stays high until acknowledged with the timer irq id.

`timescale 1ns/1ps

`include "mm_ram_config.svh"

module periph_timer import mm_ram_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  timer_wr_t  timer_wr_i,
    input  logic [4:0] irq_id_i,
    input  logic       irq_ack_i,
    output logic       irq_timer_o
);

    word_t mask_q;
    word_t cnt_q;
    logic  irq_q;
    logic  ack_hit;

    assign ack_hit = irq_ack_i && (irq_id_i == 5'(`MM_TIMER_IRQ_ID));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_q  <= 1'b0;
        end else begin
            // a register write holds off counting for that cycle
            if (timer_wr_i.mask_we) begin
                mask_q <= timer_wr_i.wdata;
            end else if (timer_wr_i.cnt_we) begin
                cnt_q <= timer_wr_i.wdata;
            end else begin
                if (cnt_q != '0) begin
                    cnt_q <= cnt_q - 1'b1;
                end
                if (cnt_q == 32'd1 && mask_q[`MM_TIMER_IRQ_ID]) begin
                    irq_q <= 1'b1;
                end
            end

            // acknowledge beats a set in the same cycle
            if (ack_hit) begin
                irq_q <= 1'b0;
            end
        end
    end

    assign irq_timer_o = irq_q;

endmodule

//--- src/mm_ram_top.sv
// Harness memory for a small RISC-V core, one shared single-port RAM.
// Data port has priority, fetches stall while the data port uses the RAM.
// Instruction addresses are truncated to the RAM region and never write.

`timescale 1ns/1ps

`include "mm_ram_config.svh"

module mm_ram_top import mm_ram_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,

    input  logic       instr_req_i,
    input  word_t      instr_addr_i,
    output logic       instr_gnt_o,
    output logic       instr_rvalid_o,
    output word_t      instr_rdata_o,

    input  logic       data_req_i,
    input  word_t      data_addr_i,
    input  logic       data_we_i,
    input  be_t        data_be_i,
    input  word_t      data_wdata_i,
    output logic       data_gnt_o,
    output logic       data_rvalid_o,
    output word_t      data_rdata_o,

    input  logic [4:0] irq_id_i,
    input  logic       irq_ack_i,
    output logic       irq_timer_o,

    output logic       tests_passed_o,
    output logic       tests_failed_o,
    output logic       exit_valid_o,
    output word_t      exit_value_o
);

    ram_req_t  instr_ram_req;
    ram_req_t  data_ram_req;
    ram_req_t  ram_req;
    timer_wr_t timer_wr;
    logic      instr_gnt;
    logic      data_gnt;
    logic      instr_rvalid;
    logic      data_rvalid;
    word_t     ram_rdata;
    word_t     sram_rdata;

    // fetches are full-word reads
    assign instr_ram_req = '{
        req:   instr_req_i,
        we:    1'b0,
        be:    4'hf,
        addr:  instr_addr_i[`MM_RAM_ADDR_WIDTH-1:2],
        wdata: '0
    };

    data_decoder u_data_decoder (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .data_ram_req_o (data_ram_req),
        .data_gnt_i     (data_gnt),
        .data_rvalid_i  (data_rvalid),
        .ram_rdata_i    (ram_rdata),
        .timer_wr_o     (timer_wr),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    mem_arbiter u_mem_arbiter (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_ram_req),
        .data_req_i     (data_ram_req),
        .instr_gnt_o    (instr_gnt),
        .data_gnt_o     (data_gnt),
        .instr_rvalid_o (instr_rvalid),
        .data_rvalid_o  (data_rvalid),
        .ram_req_o      (ram_req),
        .ram_rdata_i    (sram_rdata),
        .ram_rdata_o    (ram_rdata)
    );

    sram_model u_sram_model (
        .clk_i   (clk_i),
        .req_i   (ram_req),
        .rdata_o (sram_rdata)
    );

    periph_timer u_periph_timer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .timer_wr_i  (timer_wr),
        .irq_id_i    (irq_id_i),
        .irq_ack_i   (irq_ack_i),
        .irq_timer_o (irq_timer_o)
    );

    assign instr_gnt_o    = instr_gnt;
    assign instr_rvalid_o = instr_rvalid;
    assign instr_rdata_o  = ram_rdata;

endmodule

//--- tb/tb_mm_ram.sv
// Testbench for the harness memory with outputs sampled on falling clock edges.
// Random RAM traffic stays in words 0..63, which are written before any read.
// The shared phase keeps data traffic inside the RAM region.

`timescale 1ns/1ps

`include "mm_ram_config.svh"

module tb_mm_ram import mm_ram_pkg::*; ();

    // expected response of one accepted request
    typedef struct packed {
        logic  check;
        word_t value;
    } exp_t;

    localparam int unsigned timeout_cycles = 3000;
    localparam int unsigned ram_words      = 2 ** (`MM_RAM_ADDR_WIDTH - 2);
    localparam int unsigned test_words     = 64;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        instr_req;
    word_t       instr_addr;
    logic        instr_gnt;
    logic        instr_rvalid;
    word_t       instr_rdata;
    logic        data_req;
    word_t       data_addr;
    logic        data_we;
    be_t         data_be;
    word_t       data_wdata;
    logic        data_gnt;
    logic        data_rvalid;
    word_t       data_rdata;
    logic [4:0]  irq_id;
    logic        irq_ack;
    logic        irq_timer;
    logic        tests_passed;
    logic        tests_failed;
    logic        exit_valid;
    word_t       exit_value;

    word_t       ref_mem [ram_words];
    exp_t        data_exp_q [$];
    exp_t        instr_exp_q [$];
    string       test_name;
    int unsigned cycle_cnt;
    int unsigned data_rng;
    int unsigned fetch_rng;
    int unsigned pass_cnt;
    int unsigned fail_cnt;
    int unsigned exit_cnt;
    logic        data_in_ram;
    logic        status_wr;
    logic        exit_wr;

    // expected decode from the memory map
    assign data_in_ram = (data_addr[31:`MM_RAM_ADDR_WIDTH] == '0);
    assign status_wr   = data_req && data_we && (data_addr == `MM_STATUS_ADDR);
    assign exit_wr     = data_req && data_we && (data_addr == `MM_EXIT_ADDR);

    mm_ram_top dut_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req),
        .instr_addr_i   (instr_addr),
        .instr_gnt_o    (instr_gnt),
        .instr_rvalid_o (instr_rvalid),
        .instr_rdata_o  (instr_rdata),
        .data_req_i     (data_req),
        .data_addr_i    (data_addr),
        .data_we_i      (data_we),
        .data_be_i      (data_be),
        .data_wdata_i   (data_wdata),
        .data_gnt_o     (data_gnt),
        .data_rvalid_o  (data_rvalid),
        .data_rdata_o   (data_rdata),
        .irq_id_i       (irq_id),
        .irq_ack_i      (irq_ack),
        .irq_timer_o    (irq_timer),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed),
        .exit_valid_o   (exit_valid),
        .exit_value_o   (exit_value)
    );

    always begin
        #2 clk_i = ~clk_i;
    end

    function automatic int unsigned lcg(input int unsigned s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        stop_on_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_idle_outputs();
        logic [7:0] outs;
        outs = {instr_gnt, instr_rvalid, data_gnt, data_rvalid,
                tests_passed, tests_failed, exit_valid, irq_timer};
        assert (outs == 8'h00) else report_mismatch(test_name, 32'h0, 32'(outs));
    endtask

    // waits n rising edges and lands just after the last one
    task automatic next_cycle(input int unsigned n);
        repeat (n) begin
            @(posedge clk_i);
            #0.5;
        end
    endtask

    task automatic data_access(input word_t addr, input logic we, input be_t be,
                               input word_t wdata);
        data_req   = 1'b1;
        data_addr  = addr;
        data_we    = we;
        data_be    = be;
        data_wdata = wdata;
        @(negedge clk_i);
        while (!data_gnt) begin
            @(negedge clk_i);
        end
        next_cycle(1);
        data_req = 1'b0;
    endtask

    task automatic fetch(input word_t addr);
        instr_req  = 1'b1;
        instr_addr = addr;
        @(negedge clk_i);
        while (!instr_gnt) begin
            @(negedge clk_i);
        end
        next_cycle(1);
        instr_req = 1'b0;
    endtask

    // mostly RAM words with about one in sixteen going to an unmapped address
    task automatic random_ram_access(input logic allow_unmapped);
        word_t r;
        word_t addr;
        data_rng = lcg(data_rng);
        r        = data_rng;
        addr     = 32'(r[13:8]) << 2;
        if (allow_unmapped && r[31:28] == 4'h0) begin
            addr = 32'h3000_0000 | (32'(r[11:2]) << 2);
        end
        data_rng = lcg(data_rng);
        data_access(addr, r[27], r[19:16], data_rng);
        next_cycle(32'(r[5:4]));
    endtask

    task automatic fetch_loop(input int unsigned count);
        repeat (count) begin
            fetch_rng = lcg(fetch_rng);
            fetch(32'(fetch_rng[21:16]) << 2);
            next_cycle(32'(fetch_rng[8]));
        end
    endtask

    // a count write of n in cycle k makes the irq due from the edge ending k+n
    task automatic timer_run(input logic enabled);
        int unsigned n;
        word_t       mask;
        data_rng = lcg(data_rng);
        n        = 32'd4 + (data_rng >> 28);
        mask     = enabled ? (32'h1 << `MM_TIMER_IRQ_ID) : ~(32'h1 << `MM_TIMER_IRQ_ID);
        data_access(`MM_TIMER_MASK_ADDR, 1'b1, 4'hf, mask);
        data_access(`MM_TIMER_CNT_ADDR, 1'b1, 4'hf, n);
        repeat (n) begin
            @(negedge clk_i);
            assert (irq_timer == 1'b0) else report_mismatch(test_name, 32'd0, 32'(irq_timer));
        end
        @(negedge clk_i);
        assert (irq_timer == enabled)
            else report_mismatch(test_name, 32'(enabled), 32'(irq_timer));
        next_cycle(1);
    endtask

    task automatic ack_irq(input logic [4:0] id, input logic expect_clear);
        irq_ack = 1'b1;
        irq_id  = id;
        @(negedge clk_i);
        assert (irq_timer == 1'b1) else report_mismatch(test_name, 32'd1, 32'(irq_timer));
        next_cycle(1);
        irq_ack = 1'b0;
        @(negedge clk_i);
        assert (irq_timer == !expect_clear)
            else report_mismatch(test_name, 32'(!expect_clear), 32'(irq_timer));
        next_cycle(1);
    endtask

    // applies an accepted write to the model and queues what the read must return
    task automatic record_data_grant();
        ram_addr_t idx;
        idx = data_addr[`MM_RAM_ADDR_WIDTH-1:2];
        if (!data_in_ram) begin
            data_exp_q.push_back('{check: 1'b1, value: '0});
        end else if (data_we) begin
            for (int b = 0; b < 4; b++) begin
                if (data_be[b]) begin
                    ref_mem[idx][8*b +: 8] = data_wdata[8*b +: 8];
                end
            end
            data_exp_q.push_back('{check: 1'b0, value: '0});
        end else begin
            data_exp_q.push_back('{check: 1'b1, value: ref_mem[idx]});
        end
    endtask

    always @(negedge clk_i) begin : monitor
        exp_t e;
        if (!rst_ni) begin
            check_idle_outputs();
        end else begin
            // responses belong to last cycle's grants and are handled first
            if (data_rvalid) begin
                if (data_exp_q.size() == 0) begin
                    stop_on_error("data rvalid arrived without an accepted request");
                end else begin
                    e = data_exp_q.pop_front();
                    if (e.check) begin
                        assert (data_rdata === e.value)
                            else report_mismatch(test_name, e.value, data_rdata);
                    end
                end
            end
            if (instr_rvalid) begin
                if (instr_exp_q.size() == 0) begin
                    stop_on_error("instr rvalid arrived without an accepted request");
                end else begin
                    e = instr_exp_q.pop_front();
                    assert (instr_rdata === e.value)
                        else report_mismatch(test_name, e.value, instr_rdata);
                end
            end
            if (data_req && data_gnt) begin
                record_data_grant();
            end
            if (instr_req && instr_gnt) begin
                e = '{check: 1'b1, value: ref_mem[instr_addr[`MM_RAM_ADDR_WIDTH-1:2]]};
                instr_exp_q.push_back(e);
            end
            if (tests_passed) pass_cnt++;
            if (tests_failed) fail_cnt++;
            if (exit_valid) exit_cnt++;
        end
    end

    rvalid_after_data_gnt: assert property (@(negedge clk_i) disable iff (!rst_ni)
        data_rvalid == $past(data_gnt))
        else report_mismatch(test_name, 32'(!data_rvalid), 32'(data_rvalid));

    rvalid_after_instr_gnt: assert property (@(negedge clk_i) disable iff (!rst_ni)
        instr_rvalid == $past(instr_gnt))
        else report_mismatch(test_name, 32'(!instr_rvalid), 32'(instr_rvalid));

    // data is never stalled while a fetch loses to any RAM access of the data port
    data_gnt_rule: assert property (@(negedge clk_i) disable iff (!rst_ni)
        data_gnt == data_req)
        else report_mismatch(test_name, 32'(data_req), 32'(data_gnt));

    instr_gnt_rule: assert property (@(negedge clk_i) disable iff (!rst_ni)
        instr_gnt == (instr_req && !(data_req && data_in_ram)))
        else report_mismatch(test_name, 32'(!instr_gnt), 32'(instr_gnt));

    passed_strobe: assert property (@(negedge clk_i) disable iff (!rst_ni)
        tests_passed == (status_wr && data_wdata == `MM_PASS_VALUE))
        else report_mismatch(test_name, 32'(!tests_passed), 32'(tests_passed));

    failed_strobe: assert property (@(negedge clk_i) disable iff (!rst_ni)
        tests_failed == (status_wr && data_wdata == `MM_FAIL_VALUE))
        else report_mismatch(test_name, 32'(!tests_failed), 32'(tests_failed));

    exit_strobe: assert property (@(negedge clk_i) disable iff (!rst_ni)
        exit_valid == exit_wr)
        else report_mismatch(test_name, 32'(!exit_valid), 32'(exit_valid));

    exit_data: assert property (@(negedge clk_i) disable iff (!rst_ni)
        exit_valid |-> (exit_value == data_wdata))
        else report_mismatch(test_name, data_wdata, exit_value);

    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            stop_on_error("timeout, the tests did not finish within the cycle limit");
        end
    end

    initial begin
        rst_ni     = 1'b0;
        instr_req  = 1'b0;
        instr_addr = '0;
        data_req   = 1'b0;
        data_addr  = '0;
        data_we    = 1'b0;
        data_be    = '0;
        data_wdata = '0;
        irq_id     = '0;
        irq_ack    = 1'b0;
        test_name  = "reset";
        data_rng   = 32'd2969;
        fetch_rng  = lcg(32'd2969);
        cycle_cnt  = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        exit_cnt   = 0;

        repeat (2) @(posedge clk_i);
        #0.5;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_idle_outputs();
        next_cycle(1);

        test_name = "ram_init";
        for (int unsigned i = 0; i < test_words; i++) begin
            data_rng = lcg(data_rng);
            data_access(32'(i) << 2, 1'b1, 4'hf, data_rng);
        end

        test_name = "random_ram";
        repeat (300) random_ram_access(1'b1);

        test_name = "shared_access";
        fork
            begin
                repeat (100) random_ram_access(1'b0);
            end
            begin
                fetch_loop(150);
            end
        join

        // pass count in the upper half, fail count in the lower half
        test_name = "status_exit";
        data_access(`MM_STATUS_ADDR, 1'b1, 4'hf, `MM_PASS_VALUE);
        assert ({16'(pass_cnt), 16'(fail_cnt)} == 32'h0001_0000)
            else report_mismatch(test_name, 32'h0001_0000, {16'(pass_cnt), 16'(fail_cnt)});
        data_access(`MM_STATUS_ADDR, 1'b1, 4'hf, `MM_FAIL_VALUE);
        assert ({16'(pass_cnt), 16'(fail_cnt)} == 32'h0001_0001)
            else report_mismatch(test_name, 32'h0001_0001, {16'(pass_cnt), 16'(fail_cnt)});
        data_access(`MM_STATUS_ADDR, 1'b1, 4'hf, 32'hdead_beef);
        assert ({16'(pass_cnt), 16'(fail_cnt)} == 32'h0001_0001)
            else report_mismatch(test_name, 32'h0001_0001, {16'(pass_cnt), 16'(fail_cnt)});
        data_rng = lcg(data_rng);
        data_access(`MM_EXIT_ADDR, 1'b1, 4'hf, data_rng);
        assert (exit_cnt == 1) else report_mismatch(test_name, 32'd1, exit_cnt);

        test_name = "timer";
        timer_run(1'b1);
        next_cycle(2);
        @(negedge clk_i);
        assert (irq_timer == 1'b1) else report_mismatch(test_name, 32'd1, 32'(irq_timer));
        next_cycle(1);
        ack_irq(5'd3, 1'b0);
        ack_irq(5'(`MM_TIMER_IRQ_ID), 1'b1);
        timer_run(1'b0);

        next_cycle(4);
        test_name = "drain";
        if (data_exp_q.size() != 0 || instr_exp_q.size() != 0) begin
            stop_on_error("an accepted request never received its rvalid");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

//--- build.f
+incdir+include
src/mm_ram_pkg.sv
src/data_decoder.sv
src/mem_arbiter.sv
src/sram_model.sv
src/periph_timer.sv
src/mm_ram_top.sv
tb/tb_mm_ram.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module tb_mm_ram -o tb_mm_ram &&
./obj_dir/tb_mm_ram || exit 1
